// File: verilog/alu_defines.svh
`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// ====================
// Datapath sizes
// ====================
`define ALU_WIDTH       32
`define ALU_SLICE_W     4
`define ALU_NUM_SLICES  (`ALU_WIDTH / `ALU_SLICE_W)
`define ALU_SHAMT_W     5
`define ALU_OP_W        4

// ====================
// Operation codes
// ====================
`define OP_ADD   4'd0
`define OP_SUB   4'd1
`define OP_AND   4'd2
`define OP_XOR   4'd3
`define OP_OR    4'd4
`define OP_SLL   4'd5
`define OP_SRL   4'd6
`define OP_SLT   4'd7
`define OP_SLTU  4'd8

`endif

// File: verilog/alu_pkg.sv
`include "alu_defines.svh"

package alu_pkg;

   // Operand and result word
   typedef logic [`ALU_WIDTH-1:0] word_t;

   // Shift amount, low bits of operand B
   typedef logic [`ALU_SHAMT_W-1:0] shamt_t;

   // Bit group handled by one ripple slice
   typedef logic [`ALU_SLICE_W-1:0] slice_t;

   // Control codes 0 to 8
   // Codes 9 to 15 have no member and give a zero result
   typedef enum logic [`ALU_OP_W-1:0] {
      ALU_ADD  = `OP_ADD,
      ALU_SUB  = `OP_SUB,
      ALU_AND  = `OP_AND,
      ALU_XOR  = `OP_XOR,
      ALU_OR   = `OP_OR,
      ALU_SLL  = `OP_SLL,
      ALU_SRL  = `OP_SRL,
      ALU_SLT  = `OP_SLT,
      ALU_SLTU = `OP_SLTU
   } alu_op_t;

endpackage

// File: verilog/operand_stage.sv
`timescale 1ns/1ps

`include "alu_defines.svh"

module operand_stage import alu_pkg::*; (
   input  logic    clk,
   input  logic    rst,
   input  word_t   a,
   input  word_t   b,
   input  alu_op_t control,
   output word_t   a_q,
   output word_t   b_q,
   output word_t   b_cond,
   output logic    carry_in,
   output alu_op_t op_q,
   output shamt_t  shamt
);

   logic sub_mode;

   // Sub, slt and sltu all run the chain as a - b
   always_comb begin
      sub_mode = (control == ALU_SUB) || (control == ALU_SLT) || (control == ALU_SLTU);
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         a_q      <= '0;
         b_q      <= '0;
         b_cond   <= '0;
         carry_in <= 1'b0;
         op_q     <= ALU_ADD;
         shamt    <= '0;
      end else begin
         a_q      <= a;
         b_q      <= b;
         // Two's complement of b is ~b plus the carry-in of one
         b_cond   <= b ^ {`ALU_WIDTH{sub_mode}};
         carry_in <= sub_mode;
         op_q     <= control;
         shamt    <= b[`ALU_SHAMT_W-1:0];
      end
   end

   // Carry-in must track the registered code it was decoded from
   a_carry_in_mode: assert property (
      @(posedge clk) disable iff (rst)
      carry_in == (op_q inside {ALU_SUB, ALU_SLT, ALU_SLTU})
   ) else $error("carry_in does not match op_q %0d", op_q);

endmodule

// File: verilog/adder_slice.sv
`timescale 1ns/1ps

`include "alu_defines.svh"

module adder_slice import alu_pkg::*; (
   input  slice_t a_bits,
   input  slice_t b_bits,
   input  logic   cin,
   output slice_t sum,
   output logic   cout,
   output logic   msb_carry
);

   // ====================
   // Bitwise ripple
   // ====================
   always_comb begin
      logic [`ALU_SLICE_W:0] carry;
      carry[0] = cin;
      for (int i = 0; i < `ALU_SLICE_W; i++) begin
         sum[i]       = a_bits[i] ^ b_bits[i] ^ carry[i];
         carry[i + 1] = (a_bits[i] & b_bits[i])
                      | (a_bits[i] & carry[i])
                      | (b_bits[i] & carry[i]);
      end
      cout      = carry[`ALU_SLICE_W];
      // Carry into the top bit of this group, used for overflow
      msb_carry = carry[`ALU_SLICE_W - 1];
   end

endmodule

// File: verilog/barrel_shifter.sv
`timescale 1ns/1ps

`include "alu_defines.svh"

module barrel_shifter import alu_pkg::*; (
   input  word_t  value,
   input  shamt_t shamt,
   input  logic   shift_left,
   output word_t  shifted
);

   // One right-shift network serves both directions.
   // A left shift reverses the word on the way in and on the way out.
   always_comb begin
      word_t oriented;
      word_t staged;

      for (int i = 0; i < `ALU_WIDTH; i++) begin
         oriented[i] = shift_left ? value[`ALU_WIDTH - 1 - i] : value[i];
      end

      // Log stages where stage s moves by 2**s
      staged = oriented;
      for (int s = 0; s < `ALU_SHAMT_W; s++) begin
         if (shamt[s]) begin
            staged = staged >> (1 << s);
         end
      end

      for (int i = 0; i < `ALU_WIDTH; i++) begin
         shifted[i] = shift_left ? staged[`ALU_WIDTH - 1 - i] : staged[i];
      end
   end

endmodule

// File: verilog/result_stage.sv
`timescale 1ns/1ps

`include "alu_defines.svh"

module result_stage import alu_pkg::*; (
   input  logic    clk,
   input  logic    rst,
   input  alu_op_t op_q,
   input  word_t   a_q,
   input  word_t   b_q,
   input  word_t   sum,
   input  logic    chain_carry,
   input  logic    msb_carry,
   input  word_t   shifted,
   output word_t   result,
   output logic    carry_out,
   output logic    overflow,
   output logic    zero
);

   word_t and_w;
   word_t xor_w;
   word_t or_w;
   word_t next_result;
   logic  overflow_w;
   logic  slt_w;
   logic  sltu_w;

   // ====================
   // Flags and compares
   // ====================
   always_comb begin
      overflow_w = chain_carry ^ msb_carry;
      // Sign of a - b corrected for overflow
      slt_w      = sum[`ALU_WIDTH-1] ^ overflow_w;
      // No carry out of a + ~b + 1 means a borrow
      sltu_w     = ~chain_carry;
   end

   // ====================
   // Result select
   // ====================
   always_comb begin
      and_w = a_q & b_q;
      xor_w = a_q ^ b_q;
      or_w  = a_q | b_q;
      case (op_q)
         ALU_ADD,
         ALU_SUB:  next_result = sum;
         ALU_AND:  next_result = and_w;
         ALU_XOR:  next_result = xor_w;
         ALU_OR:   next_result = or_w;
         ALU_SLL,
         ALU_SRL:  next_result = shifted;
         ALU_SLT:  next_result = word_t'(slt_w);
         ALU_SLTU: next_result = word_t'(sltu_w);
         default:  next_result = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         result    <= '0;
         carry_out <= 1'b0;
         overflow  <= 1'b0;
         zero      <= 1'b0;
      end else begin
         result    <= next_result;
         carry_out <= chain_carry;
         overflow  <= overflow_w;
         zero      <= (next_result == '0);
      end
   end

   // Zero is registered alongside the result it describes
   a_zero_tracks_result: assert property (
      @(posedge clk) disable iff (rst)
      !rst |=> (zero == (result == '0))
   ) else $error("zero flag out of step with result %h", result);

   // Compares leave only bit 0 set
   a_compare_upper_clear: assert property (
      @(posedge clk) disable iff (rst)
      (op_q inside {ALU_SLT, ALU_SLTU}) |=> (result[`ALU_WIDTH-1:1] == '0)
   ) else $error("compare result has upper bits set: %h", result);

endmodule

// File: verilog/alu_top.sv
`timescale 1ns/1ps

`include "alu_defines.svh"

module alu_top import alu_pkg::*; (
   input  logic                 clk,
   input  logic                 rst,
   input  word_t                a,
   input  word_t                b,
   input  logic [`ALU_OP_W-1:0] control,
   output word_t                result,
   output logic                 carry_out,
   output logic                 overflow,
   output logic                 zero
);

   word_t   a_q;
   word_t   b_q;
   word_t   b_cond;
   logic    carry_in;
   alu_op_t op_q;
   shamt_t  shamt;
   word_t   sum_all;
   word_t   shifted;

   operand_stage u_operand (
      .clk      (clk),
      .rst      (rst),
      .a        (a),
      .b        (b),
      .control  (alu_op_t'(control)),
      .a_q      (a_q),
      .b_q      (b_q),
      .b_cond   (b_cond),
      .carry_in (carry_in),
      .op_q     (op_q),
      .shamt    (shamt)
   );

   // ====================
   // Ripple chain
   // ====================
   for (genvar k = 0; k < `ALU_NUM_SLICES; k++) begin : g_slice
      logic cin_k;
      logic cout_k;
      logic msb_k;

      if (k == 0) begin : g_first
         assign cin_k = carry_in;
      end else begin : g_link
         assign cin_k = g_slice[k-1].cout_k;
      end

      adder_slice u_slice (
         .a_bits    (a_q[k*`ALU_SLICE_W +: `ALU_SLICE_W]),
         .b_bits    (b_cond[k*`ALU_SLICE_W +: `ALU_SLICE_W]),
         .cin       (cin_k),
         .sum       (sum_all[k*`ALU_SLICE_W +: `ALU_SLICE_W]),
         .cout      (cout_k),
         .msb_carry (msb_k)
      );
   end

   // Sll is 5 and srl is 6, so bit 0 picks the direction
   barrel_shifter u_shifter (
      .value      (a_q),
      .shamt      (shamt),
      .shift_left (op_q[0]),
      .shifted    (shifted)
   );

   result_stage u_result (
      .clk         (clk),
      .rst         (rst),
      .op_q        (op_q),
      .a_q         (a_q),
      .b_q         (b_q),
      .sum         (sum_all),
      .chain_carry (g_slice[`ALU_NUM_SLICES-1].cout_k),
      .msb_carry   (g_slice[`ALU_NUM_SLICES-1].msb_k),
      .shifted     (shifted),
      .result      (result),
      .carry_out   (carry_out),
      .overflow    (overflow),
      .zero        (zero)
   );

endmodule

// File: tb/tb_alu_top.sv
`timescale 1ns/1ps

`include "alu_defines.svh"

module tb_alu_top import alu_pkg::*; ();

   typedef struct packed {
      word_t                op_a;
      word_t                op_b;
      logic [`ALU_OP_W-1:0] op;
      word_t                result;
      logic                 carry_out;
      logic                 overflow;
      logic                 zero;
   } expect_t;

   logic                 clk;
   logic                 rst;
   word_t                a;
   word_t                b;
   logic [`ALU_OP_W-1:0] control;
   word_t                result;
   logic                 carry_out;
   logic                 overflow;
   logic                 zero;

   integer  seed;
   int      errors = 0;
   int      checked = 0;
   int      pushed = 0;
   int      cycle = 0;
   logic    feeding = 1'b0;
   expect_t exp_q[$];
   int      tag_q[$];

   alu_top u_dut (
      .clk       (clk),
      .rst       (rst),
      .a         (a),
      .b         (b),
      .control   (control),
      .result    (result),
      .carry_out (carry_out),
      .overflow  (overflow),
      .zero      (zero)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // ====================
   // Reference model
   // ====================
   function automatic expect_t alu_model(input word_t op_a, input word_t op_b,
                                         input logic [`ALU_OP_W-1:0] op);
      expect_t               e;
      logic                  subtract;
      word_t                 b_eff;
      logic [`ALU_WIDTH:0]   wide;
      logic [`ALU_WIDTH-1:0] low;
      subtract = (op == `OP_SUB) || (op == `OP_SLT) || (op == `OP_SLTU);
      b_eff    = subtract ? ~op_b : op_b;
      // Extra top bit holds the final carry
      wide = {1'b0, op_a} + {1'b0, b_eff} + {{`ALU_WIDTH{1'b0}}, subtract};
      // The msb of the lower-bit sum is the carry into the top bit
      low  = {1'b0, op_a[`ALU_WIDTH-2:0]} + {1'b0, b_eff[`ALU_WIDTH-2:0]}
           + {{(`ALU_WIDTH-1){1'b0}}, subtract};
      e.op_a      = op_a;
      e.op_b      = op_b;
      e.op        = op;
      e.carry_out = wide[`ALU_WIDTH];
      e.overflow  = wide[`ALU_WIDTH] ^ low[`ALU_WIDTH-1];
      e.result    = '0;
      case (op)
         `OP_ADD,
         `OP_SUB:  e.result = wide[`ALU_WIDTH-1:0];
         `OP_AND:  e.result = op_a & op_b;
         `OP_XOR:  e.result = op_a ^ op_b;
         `OP_OR:   e.result = op_a | op_b;
         `OP_SLL:  e.result = op_a << op_b[`ALU_SHAMT_W-1:0];
         `OP_SRL:  e.result = op_a >> op_b[`ALU_SHAMT_W-1:0];
         `OP_SLT:  e.result[0] = $signed(op_a) < $signed(op_b);
         `OP_SLTU: e.result[0] = op_a < op_b;
         default:  e.result = '0;
      endcase
      e.zero = (e.result == '0);
      return e;
   endfunction

   // Pops the entry that is two cycles old, then queues the op now on the inputs
   task automatic compare_step();
      expect_t want;
      cycle++;
      if (exp_q.size() > 0 && cycle - tag_q[0] == 2) begin
         want = exp_q.pop_front();
         void'(tag_q.pop_front());
         checked++;
         if (result !== want.result) begin
            errors++;
            $display("FAILED at %0t: result %h, expected %h (op %0d a %h b %h)",
                     $time, result, want.result, want.op, want.op_a, want.op_b);
         end
         if (carry_out !== want.carry_out) begin
            errors++;
            $display("FAILED at %0t: carry_out %b, expected %b (op %0d a %h b %h)",
                     $time, carry_out, want.carry_out, want.op, want.op_a, want.op_b);
         end
         if (overflow !== want.overflow) begin
            errors++;
            $display("FAILED at %0t: overflow %b, expected %b (op %0d a %h b %h)",
                     $time, overflow, want.overflow, want.op, want.op_a, want.op_b);
         end
         if (zero !== want.zero) begin
            errors++;
            $display("FAILED at %0t: zero %b, expected %b (op %0d a %h b %h)",
                     $time, zero, want.zero, want.op, want.op_a, want.op_b);
         end
      end
      if (feeding) begin
         exp_q.push_back(alu_model(a, b, control));
         tag_q.push_back(cycle);
         pushed++;
      end
   endtask

   task automatic apply_op(input word_t op_a, input word_t op_b,
                           input logic [`ALU_OP_W-1:0] op);
      @(posedge clk);
      a       <= op_a;
      b       <= op_b;
      control <= op;
   endtask

   // Outputs are sampled on the falling edge between driving edges
   initial begin
      int waited;
      waited = 0;
      @(negedge clk);
      while (rst && waited < 40) begin
         @(negedge clk);
         waited++;
      end
      if (rst) begin
         $display("Reset was not released within 40 cycles");
         $display("test failed");
         $finish;
      end else begin
         forever begin
            compare_step();
            @(negedge clk);
         end
      end
   end

   // ====================
   // Stimulus
   // ====================
   initial begin
      logic [31:0] r;
      word_t       ra;
      int          guard;
      seed    = 11;
      rst     = 1'b1;
      a       = '0;
      b       = '0;
      control = '0;

      repeat (15) @(posedge clk);
      @(negedge clk);
      if (result !== '0 || carry_out !== 1'b0 || overflow !== 1'b0 || zero !== 1'b0) begin
         errors++;
         $display("FAILED at %0t: outputs not cleared by reset", $time);
      end
      @(posedge clk);
      rst     <= 1'b0;
      feeding = 1'b1;

      // Carry and overflow corners
      apply_op(32'h7FFF_FFFF, 32'h0000_0001, `OP_ADD);
      apply_op(32'h8000_0000, 32'h0000_0001, `OP_SUB);
      apply_op(32'h0000_0000, 32'h0000_0001, `OP_SUB);
      apply_op(32'hFFFF_FFFF, 32'h0000_0001, `OP_ADD);
      apply_op(32'h1234_ABCD, 32'h1234_ABCD, `OP_SUB);

      // Every shift amount with random noise in the upper bits of b
      for (int s = 0; s < `ALU_WIDTH; s++) begin
         ra = $random(seed);
         r  = $random(seed);
         apply_op(ra, {r[31:`ALU_SHAMT_W], s[`ALU_SHAMT_W-1:0]}, `OP_SLL);
         r  = $random(seed);
         apply_op(ra, {r[31:`ALU_SHAMT_W], s[`ALU_SHAMT_W-1:0]}, `OP_SRL);
      end

      // Signed and unsigned compare boundaries
      for (int c = 0; c < 2; c++) begin
         apply_op(32'h8000_0000, 32'h0000_0001, c ? `OP_SLTU : `OP_SLT);
         apply_op(32'h0000_0001, 32'h8000_0000, c ? `OP_SLTU : `OP_SLT);
         apply_op(32'h0000_0005, 32'h0000_0005, c ? `OP_SLTU : `OP_SLT);
         apply_op(32'hFFFF_FFFF, 32'h0000_0000, c ? `OP_SLTU : `OP_SLT);
         apply_op(32'h7FFF_FFFF, 32'h8000_0000, c ? `OP_SLTU : `OP_SLT);
      end

      // Unused codes
      for (int c = 9; c < 16; c++) begin
         apply_op($random(seed), $random(seed), c[`ALU_OP_W-1:0]);
      end

      for (int i = 0; i < 400; i++) begin
         r = $random(seed);
         apply_op($random(seed), $random(seed), r[`ALU_OP_W-1:0]);
      end

      @(posedge clk);
      feeding = 1'b0;
      guard   = 0;
      while (checked < pushed && guard < 10) begin
         @(posedge clk);
         guard++;
      end
      if (checked != pushed) begin
         errors++;
         $display("Timed out with %0d results never checked", pushed - checked);
      end

      $display("Checked %0d results, %0d errors", checked, errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

// File: alu_top.f
+incdir+verilog
verilog/alu_pkg.sv
verilog/operand_stage.sv
verilog/adder_slice.sv
verilog/barrel_shifter.sv
verilog/result_stage.sv
verilog/alu_top.sv
tb/tb_alu_top.sv

// File: Makefile
TOP = tb_alu_top

.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f alu_top.f
	./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	@if grep -q "test failed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
